//--- hw/neu_pkg.sv
// ========================================
// Convolution sequencer shared types.
// Widths, phase and mode codes, run
// configuration and tile descriptors.
// ========================================

package neu_pkg;

  localparam int unsigned IDX_W     = 8;
  localparam int unsigned ADDR_W    = 32;
  localparam int unsigned NUM_LOOPS = 4;

  typedef enum logic {
    NORMAL    = 1'b0,
    DEPTHWISE = 1'b1
  } filter_mode_e;

  typedef enum logic [2:0] {
    LOAD           = 3'd0,
    WEIGHTOFFS     = 3'd1,
    MATRIXVEC      = 3'd2,
    NORMQUANT      = 3'd3,
    NORMQUANT_BIAS = 3'd4,
    STREAMOUT      = 3'd5
  } phase_e;

  // the counter word, innermost loop in the low bits.
  typedef union packed {
    logic [NUM_LOOPS-1:0][IDX_W-1:0] cnt;
    struct packed {
      logic [IDX_W-1:0] k_out;
      logic [IDX_W-1:0] i;
      logic [IDX_W-1:0] j;
      logic [IDX_W-1:0] k_in;
    } normal;
    struct packed {
      logic [IDX_W-1:0] unused;
      logic [IDX_W-1:0] k;
      logic [IDX_W-1:0] i;
      logic [IDX_W-1:0] j;
    } dw;
  } loop_idx_u;

  typedef struct packed {
    logic [IDX_W-1:0] k_out;
    logic [IDX_W-1:0] i;
    logic [IDX_W-1:0] j;
    logic [IDX_W-1:0] k_in;
  } tile_index_t;

  typedef struct packed {
    logic [ADDR_W-1:0] weights;
    logic [ADDR_W-1:0] infeat;
    logic [ADDR_W-1:0] outfeat;
    logic [ADDR_W-1:0] scale;
  } base_addr_t;

  typedef struct packed {
    tile_index_t idx;
    base_addr_t  addr;
  } tile_t;

  // in depthwise mode k runs over range.k_out and range.k_in is ignored.
  typedef struct packed {
    filter_mode_e      mode;
    tile_index_t       range;
    logic              quant_en;
    logic              bias_en;
    logic [ADDR_W-1:0] weights_kout_stride;
    logic [ADDR_W-1:0] weights_kin_stride;
    logic [ADDR_W-1:0] infeat_i_stride;
    logic [ADDR_W-1:0] infeat_j_stride;
    logic [ADDR_W-1:0] infeat_kin_stride;
    logic [ADDR_W-1:0] outfeat_i_stride;
    logic [ADDR_W-1:0] outfeat_j_stride;
    logic [ADDR_W-1:0] outfeat_kout_stride;
    logic [ADDR_W-1:0] scale_kout_stride;
    base_addr_t        start;
  } ctrl_cfg_t;

  typedef struct packed {
    logic   valid;
    phase_e phase;
  } engine_req_t;

  typedef struct packed {
    logic acc_continue;
    logic last;
  } loop_status_t;

endpackage

//--- hw/neu_loop_nest.sv
// ========================================
// Tile loop nest.
// Four counters with a carry chain, three
// in depthwise mode, plus loop status.
// ========================================

`timescale 1ns/100ps

module neu_loop_nest #(
  parameter int unsigned IDX_W = neu_pkg::IDX_W
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  clear_i,
  input  neu_pkg::filter_mode_e mode_i,
  input  neu_pkg::tile_index_t  range_i,
  input  logic                  step_i,
  output neu_pkg::loop_idx_u    idx_o,
  output neu_pkg::loop_status_t status_o
);

  import neu_pkg::*;

  logic [NUM_LOOPS-1:0][IDX_W-1:0] cnt_d, cnt_q;
  logic [NUM_LOOPS-1:0][IDX_W-1:0] range_pos;
  logic [NUM_LOOPS-1:0]            at_max;
  logic [NUM_LOOPS-1:0]            carry;
  loop_status_t                    status_d, status_q;

  // map the named ranges onto counter positions, innermost first.
  // the unused depthwise loop gets a range of one, so it never counts
  // and always reads as wrapped.
  always_comb begin : range_map
    if (mode_i == DEPTHWISE) begin
      range_pos[0] = range_i.j;
      range_pos[1] = range_i.i;
      range_pos[2] = range_i.k_out;
      range_pos[3] = IDX_W'(1);
    end else begin
      range_pos[0] = range_i.k_in;
      range_pos[1] = range_i.j;
      range_pos[2] = range_i.i;
      range_pos[3] = range_i.k_out;
    end
  end

  always_comb begin : max_detect
    for (int n = 0; n < NUM_LOOPS; n++) begin
      at_max[n] = (cnt_q[n] == range_pos[n] - IDX_W'(1));
    end
  end

  // a loop advances when every loop inside it wraps on this step.
  always_comb begin : carry_chain
    carry[0] = step_i;
    for (int n = 1; n < NUM_LOOPS; n++) begin
      carry[n] = carry[n-1] & at_max[n-1];
    end
  end

  always_comb begin : cnt_next
    cnt_d = cnt_q;
    for (int n = 0; n < NUM_LOOPS; n++) begin
      if (carry[n]) begin
        cnt_d[n] = at_max[n] ? '0 : cnt_q[n] + IDX_W'(1);
      end
    end
    if (clear_i) begin
      cnt_d = '0;
    end
  end

  // accumulation goes on while the input-channel loop has not wrapped.
  assign status_d.last         = &at_max;
  assign status_d.acc_continue = (mode_i == NORMAL) & ~at_max[0];

  always_ff @(posedge clk_i or negedge rst_ni) begin : cnt_reg
    if (!rst_ni) begin
      cnt_q    <= '0;
      status_q <= '0;
    end else begin
      cnt_q    <= cnt_d;
      status_q <= status_d;
    end
  end

  assign idx_o.cnt = cnt_q;
  assign status_o  = status_q;

  // the sequencer must stop stepping once the whole nest is done.
  a_no_step_after_last : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    step_i |-> !status_q.last
  ) else $error("loop step issued on the last tile");

endmodule

//--- hw/neu_addr_gen.sv
// ========================================
// Tile address generator.
// Decodes the counter word per mode and
// forms the four base addresses.
// ========================================

`timescale 1ns/100ps

module neu_addr_gen #(
  parameter int unsigned IDX_W  = neu_pkg::IDX_W,
  parameter int unsigned ADDR_W = neu_pkg::ADDR_W
) (
  input  neu_pkg::ctrl_cfg_t cfg_i,
  input  neu_pkg::loop_idx_u idx_i,
  output neu_pkg::tile_t     tile_o
);

  import neu_pkg::*;

  tile_index_t       idx;
  logic [ADDR_W-1:0] addr_weights;
  logic [ADDR_W-1:0] addr_infeat;
  logic [ADDR_W-1:0] addr_outfeat;
  logic [ADDR_W-1:0] addr_scale;

  function automatic logic [ADDR_W-1:0] offs(
    input logic [IDX_W-1:0]  cnt,
    input logic [ADDR_W-1:0] stride
  );
    return ADDR_W'(cnt) * stride;
  endfunction

  // depthwise tiles use the same channel index on both sides.
  always_comb begin : idx_decode
    if (cfg_i.mode == DEPTHWISE) begin
      idx.k_out = idx_i.dw.k;
      idx.i     = idx_i.dw.i;
      idx.j     = idx_i.dw.j;
      idx.k_in  = idx_i.dw.k;
    end else begin
      idx.k_out = idx_i.normal.k_out;
      idx.i     = idx_i.normal.i;
      idx.j     = idx_i.normal.j;
      idx.k_in  = idx_i.normal.k_in;
    end
  end

  assign addr_weights = cfg_i.start.weights
                      + offs(idx.k_out, cfg_i.weights_kout_stride)
                      + offs(idx.k_in, cfg_i.weights_kin_stride);

  assign addr_infeat = cfg_i.start.infeat
                     + offs(idx.i, cfg_i.infeat_i_stride)
                     + offs(idx.j, cfg_i.infeat_j_stride)
                     + offs(idx.k_in, cfg_i.infeat_kin_stride);

  assign addr_outfeat = cfg_i.start.outfeat
                      + offs(idx.i, cfg_i.outfeat_i_stride)
                      + offs(idx.j, cfg_i.outfeat_j_stride)
                      + offs(idx.k_out, cfg_i.outfeat_kout_stride);

  assign addr_scale = cfg_i.start.scale + offs(idx.k_out, cfg_i.scale_kout_stride);

  assign tile_o.idx          = idx;
  assign tile_o.addr.weights = addr_weights;
  assign tile_o.addr.infeat  = addr_infeat;
  assign tile_o.addr.outfeat = addr_outfeat;
  assign tile_o.addr.scale   = addr_scale;

endmodule

//--- hw/neu_ctrl_fsm.sv
// ========================================
// Convolution sequencer FSM.
// Runs the engine phases per tile and
// steps the loop nest.
// ========================================

`timescale 1ns/100ps

module neu_ctrl_fsm (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  clear_i,
  input  logic                  start_i,
  input  logic                  cfg_quant_en_i,
  input  logic                  cfg_bias_en_i,
  input  logic                  engine_done_i,
  input  logic                  store_idle_i,
  input  neu_pkg::loop_status_t status_i,
  output neu_pkg::engine_req_t  req_o,
  output logic                  loop_step_o,
  output logic                  loop_clear_o,
  output logic                  busy_o,
  output logic                  done_o
);

  import neu_pkg::*;

  typedef enum logic [3:0] {
    ST_IDLE,
    ST_LOAD,
    ST_WEIGHTOFFS,
    ST_MATRIXVEC,
    ST_UPDATEIDX,
    ST_NORMQUANT,
    ST_NORMQUANT_BIAS,
    ST_STREAMOUT,
    ST_STREAMOUT_WAIT,
    ST_UPDATEIDX_STEP,
    ST_DONE
  } state_e;

  state_e state_d, state_q;

  always_comb begin : next_state
    state_d = state_q;
    unique case (state_q)
      ST_IDLE: begin
        if (start_i) state_d = ST_LOAD;
      end
      ST_LOAD: begin
        if (engine_done_i) state_d = ST_WEIGHTOFFS;
      end
      ST_WEIGHTOFFS: begin
        if (engine_done_i) state_d = ST_MATRIXVEC;
      end
      ST_MATRIXVEC: begin
        if (engine_done_i) state_d = ST_UPDATEIDX;
      end
      // partial sums stay in the accumulators until k_in wraps.
      ST_UPDATEIDX: begin
        if (status_i.acc_continue) begin
          state_d = ST_LOAD;
        end else if (cfg_quant_en_i) begin
          state_d = ST_NORMQUANT;
        end else begin
          state_d = ST_STREAMOUT;
        end
      end
      ST_NORMQUANT: begin
        if (engine_done_i) state_d = cfg_bias_en_i ? ST_NORMQUANT_BIAS : ST_STREAMOUT;
      end
      ST_NORMQUANT_BIAS: begin
        if (engine_done_i) state_d = ST_STREAMOUT;
      end
      ST_STREAMOUT: begin
        if (engine_done_i) state_d = status_i.last ? ST_DONE : ST_STREAMOUT_WAIT;
      end
      // the next tile may not load before the store path has drained.
      ST_STREAMOUT_WAIT: begin
        if (store_idle_i) state_d = ST_UPDATEIDX_STEP;
      end
      ST_UPDATEIDX_STEP: state_d = ST_LOAD;
      ST_DONE:           state_d = ST_IDLE;
      default:           state_d = ST_IDLE;
    endcase
    if (clear_i) begin
      state_d = ST_IDLE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : state_reg
    if (!rst_ni) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin : req_decode
    req_o.valid = 1'b1;
    req_o.phase = LOAD;
    unique case (state_q)
      ST_LOAD:           req_o.phase = LOAD;
      ST_WEIGHTOFFS:     req_o.phase = WEIGHTOFFS;
      ST_MATRIXVEC:      req_o.phase = MATRIXVEC;
      ST_NORMQUANT:      req_o.phase = NORMQUANT;
      ST_NORMQUANT_BIAS: req_o.phase = NORMQUANT_BIAS;
      ST_STREAMOUT:      req_o.phase = STREAMOUT;
      default:           req_o.valid = 1'b0;
    endcase
  end

  assign loop_step_o  = ((state_q == ST_UPDATEIDX) & status_i.acc_continue)
                      | (state_q == ST_UPDATEIDX_STEP);
  assign loop_clear_o = (state_q == ST_IDLE) | clear_i;
  assign busy_o       = (state_q != ST_IDLE);
  assign done_o       = (state_q == ST_DONE);

  a_done_with_req : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    engine_done_i |-> req_o.valid
  ) else $error("engine done without a pending request");

  a_req_stable : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    req_o.valid && !engine_done_i && !clear_i |=> req_o.valid && $stable(req_o.phase)
  ) else $error("request dropped or changed before engine done");

  a_step_state : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    loop_step_o |-> state_q inside {ST_UPDATEIDX, ST_UPDATEIDX_STEP}
  ) else $error("loop step outside an index update state");

endmodule

//--- hw/neu_ctrl_top.sv
// ========================================
// Convolution control sequencer top.
// Connects the FSM, loop nest and address
// generator.
// ========================================

`timescale 1ns/100ps

module neu_ctrl_top #(
  parameter int unsigned IDX_W  = neu_pkg::IDX_W,
  parameter int unsigned ADDR_W = neu_pkg::ADDR_W
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 clear_i,
  input  logic                 start_i,
  input  neu_pkg::ctrl_cfg_t   cfg_i,
  input  logic                 engine_done_i,
  input  logic                 store_idle_i,
  output neu_pkg::engine_req_t req_o,
  output neu_pkg::tile_t       tile_o,
  output logic                 busy_o,
  output logic                 done_o
);

  import neu_pkg::*;

  loop_idx_u    loop_idx;
  loop_status_t loop_status;
  logic         loop_step;
  logic         loop_clear;

  neu_ctrl_fsm u_fsm (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .clear_i        ( clear_i        ),
    .start_i        ( start_i        ),
    .cfg_quant_en_i ( cfg_i.quant_en ),
    .cfg_bias_en_i  ( cfg_i.bias_en  ),
    .engine_done_i  ( engine_done_i  ),
    .store_idle_i   ( store_idle_i   ),
    .status_i       ( loop_status    ),
    .req_o          ( req_o          ),
    .loop_step_o    ( loop_step      ),
    .loop_clear_o   ( loop_clear     ),
    .busy_o         ( busy_o         ),
    .done_o         ( done_o         )
  );

  neu_loop_nest #(
    .IDX_W ( IDX_W )
  ) u_loop_nest (
    .clk_i    ( clk_i       ),
    .rst_ni   ( rst_ni      ),
    .clear_i  ( loop_clear  ),
    .mode_i   ( cfg_i.mode  ),
    .range_i  ( cfg_i.range ),
    .step_i   ( loop_step   ),
    .idx_o    ( loop_idx    ),
    .status_o ( loop_status )
  );

  neu_addr_gen #(
    .IDX_W  ( IDX_W  ),
    .ADDR_W ( ADDR_W )
  ) u_addr_gen (
    .cfg_i  ( cfg_i    ),
    .idx_i  ( loop_idx ),
    .tile_o ( tile_o   )
  );

endmodule

//--- include/neu_tb_vectors.svh
// ========================================
// Sequencer test vectors.
// One row per run, with expected counts.
// ========================================

`ifndef NEU_TB_VECTORS_SVH
`define NEU_TB_VECTORS_SVH

// columns are mode, ranges k_out i j k_in, quant_en, bias_en, start base,
// expected LOAD count, expected STREAMOUT count and clear-after cycle.
typedef struct packed {
  filter_mode_e mode;
  logic [7:0]   r_kout;
  logic [7:0]   r_i;
  logic [7:0]   r_j;
  logic [7:0]   r_kin;
  logic         quant_en;
  logic         bias_en;
  logic [31:0]  start_base;
  logic [15:0]  exp_loads;
  logic [15:0]  exp_streamouts;
  logic [15:0]  clear_after;
} vec_row_t;

localparam int NUM_ROWS = 9;

vec_row_t vectors [NUM_ROWS];

// depthwise rows carry a k_in range that the sequencer must ignore.
task fill_vectors();
  vectors[0] = '{NORMAL, 8'd2, 8'd2, 8'd2, 8'd3, 1'b0, 1'b1, 32'h0100_0000, 16'd24, 16'd8, 16'd0};
  vectors[1] = '{NORMAL, 8'd2, 8'd1, 8'd3, 8'd2, 1'b1, 1'b0, 32'h0200_0000, 16'd12, 16'd6, 16'd0};
  vectors[2] = '{NORMAL, 8'd1, 8'd2, 8'd2, 8'd1, 1'b1, 1'b1, 32'h0300_0000, 16'd4, 16'd4, 16'd0};
  vectors[3] = '{DEPTHWISE, 8'd3, 8'd2, 8'd2, 8'd5, 1'b0, 1'b0, 32'h0400_0000, 16'd12, 16'd12,
                 16'd0};
  vectors[4] = '{DEPTHWISE, 8'd2, 8'd2, 8'd3, 8'd1, 1'b1, 1'b0, 32'h0500_0000, 16'd12, 16'd12,
                 16'd0};
  vectors[5] = '{DEPTHWISE, 8'd2, 8'd3, 8'd1, 8'd2, 1'b1, 1'b1, 32'h0600_0000, 16'd6, 16'd6,
                 16'd0};
  vectors[6] = '{NORMAL, 8'd3, 8'd3, 8'd3, 8'd2, 1'b1, 1'b1, 32'h0700_0000, 16'd54, 16'd27, 16'd40};
  vectors[7] = '{NORMAL, 8'd3, 8'd3, 8'd3, 8'd2, 1'b1, 1'b1, 32'h0700_0000, 16'd54, 16'd27, 16'd0};
  vectors[8] = '{NORMAL, 8'd1, 8'd1, 8'd1, 8'd1, 1'b0, 1'b0, 32'h0800_0000, 16'd1, 16'd1, 16'd0};
endtask

`endif

//--- dv/tb_neu_ctrl.sv
// ========================================
// Convolution sequencer testbench.
// Engine and store models, a reference
// loop model and a request checker.
// ========================================

`timescale 1ns/100ps

module tb_neu_ctrl;

  import neu_pkg::*;

  `include "neu_tb_vectors.svh"

  logic        clk_i;
  logic        rst_ni;
  logic        clear_i;
  logic        start_i;
  ctrl_cfg_t   cfg_i;
  logic        engine_done_i = 1'b0;
  logic        store_idle_i  = 1'b1;
  engine_req_t req_o;
  tile_t       tile_o;
  logic        busy_o;
  logic        done_o;

  integer      seed        = 32'hcb8d;
  int          delay_cnt   = 0;
  int          stall_cnt   = 0;
  logic        eng_pending = 1'b0;
  phase_e      exp_phase [$];
  tile_t       exp_tile [$];
  int          exp_ptr     = 0;
  int          load_cnt    = 0;
  int          so_cnt      = 0;
  int          done_cnt    = 0;
  logic        in_req      = 1'b0;
  logic        wait_store  = 1'b0;
  phase_e      cur_phase   = LOAD;
  tile_t       cur_tile    = '0;
  int          cycle_cnt   = 0;
  int          cycle_limit = 1000;

  neu_ctrl_top #(
    .IDX_W  ( IDX_W  ),
    .ADDR_W ( ADDR_W )
  ) UUT (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .clear_i       ( clear_i       ),
    .start_i       ( start_i       ),
    .cfg_i         ( cfg_i         ),
    .engine_done_i ( engine_done_i ),
    .store_idle_i  ( store_idle_i  ),
    .req_o         ( req_o         ),
    .tile_o        ( tile_o        ),
    .busy_o        ( busy_o        ),
    .done_o        ( done_o        )
  );

  initial begin : clk_gen
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  task automatic check_equal(input logic [255:0] actual, input logic [255:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("** Error at %0d ns: %s, got %0h, expected %0h", $time, what, actual, expected);
      $display("Test failures found");
      $fatal(1);
    end
  endtask

  function automatic ctrl_cfg_t make_cfg(input vec_row_t v);
    ctrl_cfg_t cfg;
    cfg                     = '0;
    cfg.mode                = v.mode;
    cfg.range               = '{v.r_kout, v.r_i, v.r_j, v.r_kin};
    cfg.quant_en            = v.quant_en;
    cfg.bias_en             = v.bias_en;
    cfg.weights_kout_stride = 32'h0000_1200;
    cfg.weights_kin_stride  = 32'h0000_0090;
    cfg.infeat_i_stride     = 32'h0000_0310;
    cfg.infeat_j_stride     = 32'h0000_0024;
    cfg.infeat_kin_stride   = 32'h0000_5000;
    cfg.outfeat_i_stride    = 32'h0000_0280;
    cfg.outfeat_j_stride    = 32'h0000_0014;
    cfg.outfeat_kout_stride = 32'h0000_0a00;
    cfg.scale_kout_stride   = 32'h0000_0008;
    cfg.start.weights       = v.start_base;
    cfg.start.infeat        = v.start_base + 32'h0010_0000;
    cfg.start.outfeat       = v.start_base + 32'h0020_0000;
    cfg.start.scale         = v.start_base + 32'h0030_0000;
    return cfg;
  endfunction

  // each base address is the tensor start plus index times stride.
  function automatic base_addr_t tile_base(input ctrl_cfg_t c, input tile_index_t t);
    base_addr_t a;
    a.weights = c.start.weights + t.k_out * c.weights_kout_stride
              + t.k_in * c.weights_kin_stride;
    a.infeat  = c.start.infeat + t.i * c.infeat_i_stride + t.j * c.infeat_j_stride
              + t.k_in * c.infeat_kin_stride;
    a.outfeat = c.start.outfeat + t.i * c.outfeat_i_stride + t.j * c.outfeat_j_stride
              + t.k_out * c.outfeat_kout_stride;
    a.scale   = c.start.scale + t.k_out * c.scale_kout_stride;
    return a;
  endfunction

  task automatic push_tile(input ctrl_cfg_t c, input tile_index_t t, input logic out_path);
    tile_t tl;
    tl.idx  = t;
    tl.addr = tile_base(c, t);
    exp_phase.push_back(LOAD);
    exp_phase.push_back(WEIGHTOFFS);
    exp_phase.push_back(MATRIXVEC);
    repeat (3) exp_tile.push_back(tl);
    if (out_path) begin
      if (c.quant_en) begin
        exp_phase.push_back(NORMQUANT);
        exp_tile.push_back(tl);
      end
      if (c.quant_en && c.bias_en) begin
        exp_phase.push_back(NORMQUANT_BIAS);
        exp_tile.push_back(tl);
      end
      exp_phase.push_back(STREAMOUT);
      exp_tile.push_back(tl);
    end
  endtask

  // normal mode writes out when k_in wraps, depthwise after every tile.
  task automatic build_reference(input ctrl_cfg_t c);
    exp_phase.delete();
    exp_tile.delete();
    exp_ptr = 0;
    for (int ko = 0; ko < c.range.k_out; ko++) begin
      for (int ii = 0; ii < c.range.i; ii++) begin
        for (int jj = 0; jj < c.range.j; jj++) begin
          if (c.mode == DEPTHWISE) begin
            push_tile(c, '{ko[7:0], ii[7:0], jj[7:0], ko[7:0]}, 1'b1);
          end else begin
            for (int ki = 0; ki < c.range.k_in; ki++) begin
              push_tile(c, '{ko[7:0], ii[7:0], jj[7:0], ki[7:0]}, ki == c.range.k_in - 1);
            end
          end
        end
      end
    end
  endtask

  always @(posedge clk_i) begin : engine_model
    if (!rst_ni || clear_i) begin
      engine_done_i <= 1'b0;
      eng_pending = 1'b0;
    end else if (engine_done_i) begin
      engine_done_i <= 1'b0;
      eng_pending = 1'b0;
    end else if (req_o.valid) begin
      if (!eng_pending) begin
        delay_cnt   = {$random(seed)} % 4;
        eng_pending = 1'b1;
      end
      if (delay_cnt == 0) begin
        engine_done_i <= 1'b1;
      end else begin
        delay_cnt--;
      end
    end
    if (stall_cnt > 0) begin
      store_idle_i <= 1'b0;
      stall_cnt--;
    end else if ({$random(seed)} % 4 == 0) begin
      store_idle_i <= 1'b0;
      stall_cnt = {$random(seed)} % 6;
    end else begin
      store_idle_i <= 1'b1;
    end
  end

  always @(posedge clk_i) begin : monitor
    if (!rst_ni || clear_i) begin
      in_req     = 1'b0;
      wait_store = 1'b0;
    end else begin
      if (in_req) begin
        check_equal(req_o.valid, 1'b1, "request held until engine done");
        check_equal(req_o.phase, cur_phase, "phase stable while pending");
        check_equal(tile_o, cur_tile, "tile stable while pending");
      end else if (req_o.valid) begin
        check_equal(exp_ptr < exp_phase.size(), 1'b1, "request within reference sequence");
        check_equal(req_o.phase, exp_phase[exp_ptr], "request phase");
        check_equal(tile_o, exp_tile[exp_ptr], "request tile");
        if (req_o.phase == LOAD) begin
          check_equal(wait_store, 1'b0, "load only after store idle");
          load_cnt++;
        end
        if (req_o.phase == STREAMOUT) so_cnt++;
        cur_phase = req_o.phase;
        cur_tile  = tile_o;
        in_req    = 1'b1;
        exp_ptr++;
      end
      if (store_idle_i) wait_store = 1'b0;
      if (in_req && engine_done_i) begin
        in_req = 1'b0;
        if (cur_phase == STREAMOUT && exp_ptr < exp_phase.size()) wait_store = 1'b1;
      end
      if (done_o) done_cnt++;
    end
  end

  always @(posedge clk_i) begin : watchdog
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      $display("Timeout: the sequencer did not finish within %0d cycles", cycle_limit);
      $display("Test failures found");
      $fatal(1);
    end
  end

  task automatic run_row(input int r);
    vec_row_t  v;
    ctrl_cfg_t cfg;
    v   = vectors[r];
    cfg = make_cfg(v);
    build_reference(cfg);
    load_cnt = 0;
    so_cnt   = 0;
    done_cnt = 0;
    @(posedge clk_i);
    check_equal(req_o.valid, 1'b0, "no request while idle");
    check_equal(busy_o, 1'b0, "not busy while idle");
    check_equal(done_o, 1'b0, "no done while idle");
    cfg_i   <= cfg;
    start_i <= 1'b1;
    @(posedge clk_i);
    start_i <= 1'b0;
    @(posedge clk_i);
    check_equal(req_o.valid, 1'b1, "request one cycle after start");
    check_equal(req_o.phase, LOAD, "first phase after start");
    if (v.clear_after != 0) begin
      repeat (v.clear_after) @(posedge clk_i);
      clear_i <= 1'b1;
      @(posedge clk_i);
      clear_i <= 1'b0;
      @(posedge clk_i);
      check_equal(req_o.valid, 1'b0, "request dropped after clear");
      check_equal(busy_o, 1'b0, "idle after clear");
      repeat (3) @(posedge clk_i);
      check_equal(done_cnt, 0, "no done pulse after clear");
      check_equal(busy_o, 1'b0, "still idle after clear");
    end else begin
      do @(posedge clk_i); while (!done_o);
      @(posedge clk_i);
      check_equal(done_o, 1'b0, "done lasts one cycle");
      check_equal(busy_o, 1'b0, "busy falls after done");
      check_equal(req_o.valid, 1'b0, "no request after done");
      @(posedge clk_i);
      check_equal(done_cnt, 1, "one done pulse per run");
      check_equal(load_cnt, v.exp_loads, "LOAD count");
      check_equal(so_cnt, v.exp_streamouts, "STREAMOUT count");
      check_equal(exp_ptr, exp_phase.size(), "full reference sequence seen");
    end
  endtask

  initial begin : main_seq
    rst_ni  = 1'b0;
    clear_i = 1'b0;
    start_i = 1'b0;
    cfg_i   = '0;
    fill_vectors();
    for (int r = 0; r < NUM_ROWS; r++) begin
      cycle_limit += vectors[r].exp_loads * 6 * 8;
    end
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    check_equal({req_o.valid, busy_o, done_o}, 3'b000, "outputs low after reset");
    for (int r = 0; r < NUM_ROWS; r++) begin
      run_row(r);
    end
    $display("All tests passed!");
    $finish;
  end

endmodule

//--- compile.f
+incdir+include
hw/neu_pkg.sv
hw/neu_loop_nest.sv
hw/neu_addr_gen.sv
hw/neu_ctrl_fsm.sv
hw/neu_ctrl_top.sv
dv/tb_neu_ctrl.sv

//--- Bender.yml
package:
  name: neu_ctrl

sources:
  - hw/neu_pkg.sv
  - hw/neu_loop_nest.sv
  - hw/neu_addr_gen.sv
  - hw/neu_ctrl_fsm.sv
  - hw/neu_ctrl_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/tb_neu_ctrl.sv
